// ==== verilog/hip_pkg.sv ====
`default_nettype none

package hip_pkg;

	localparam int CNT_W = 16;	// Release counter width

	// Power-on style defaults for the real board, about 0.6 ms at 100 MHz for PMC
	localparam logic [CNT_W-1:0] DEF_PCI_DELAY = 16'd255;	// PCI release delay
	localparam logic [CNT_W-1:0] DEF_PMC_DELAY = 16'd65520;	// PMC release delay

	// Sequencer phase
	typedef enum logic [1:0]
	{
		RS_HOLD   = 2'b00,	// Everything held
		RS_PCI_UP = 2'b01,	// PCI out, PMC still held
		RS_ALL_UP = 2'b10	// Sequence done
	} rst_state_e;

	// Reset levels, low = held
	typedef struct packed
	{
		logic pci_rst_n;	// Yeti PCI reset
		logic pmc_rst_n;	// PPMC reset
		logic slot_rst_n;	// PCI and PCI-X slots
	} rst_status_t;

	// Synchronized Ewok lines, high = request
	typedef struct packed
	{
		logic e1_int0;	// Ewok1 line 0
		logic e1_int1;	// Ewok1 line 1
		logic e2_int0;	// Ewok2 line 0
		logic e2_int1;	// Ewok2 line 1
	} irq_raw_t;

	// Mapped requests, high = request
	typedef struct packed
	{
		logic [3:0] intx;	// Bit 0 = INTA ... bit 3 = INTD
		logic [5:0] pmc;	// Extra PPMC interrupts
	} irq_vec_t;

endpackage

`default_nettype wire

// ==== verilog/rst_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rst_sequencer
	import hip_pkg::*;
#(
	parameter logic [CNT_W-1:0] PCI_DELAY = DEF_PCI_DELAY,	// Edges before PCI release
	parameter logic [CNT_W-1:0] PMC_DELAY = DEF_PMC_DELAY	// Edges before PMC release
)
(
	input  logic        RST_CPLD_CLK,	// Board CPLD clock
	input  logic        PUSH_RST_,	// Push button, async
	input  logic        rst_out_n,	// RST_OUT_ from the PPMC
	output rst_status_t status,	// Reset levels to the output stage
	output rst_state_e  phase	// Current release phase
);

	logic [CNT_W-1:0] cnt;	// Release counter
	rst_state_e       phase_nxt;	// Next phase
	logic             rst_out_q;	// RST_OUT_ sample
	logic             slot_rst_q;	// Slot release flop

	// Counter runs from button release and parks at PMC_DELAY
	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			cnt <= '0;	// Restart count
		end
		else if (cnt < PMC_DELAY)
		begin
			cnt <= cnt + 1'b1;	// Keep counting
		end
	end

	// Phase decode from the counter
	always_comb
	begin
		phase_nxt = phase;	// Default hold
		case (phase)
			RS_HOLD:
			begin
				if (cnt >= PCI_DELAY)
				begin
					phase_nxt = RS_PCI_UP;	// PCI delay done
				end
			end
			RS_PCI_UP:
			begin
				if (cnt == PMC_DELAY)
				begin
					phase_nxt = RS_ALL_UP;	// PMC delay done
				end
			end
			RS_ALL_UP:
			begin
				phase_nxt = RS_ALL_UP;	// Stays until next push
			end
			default:
			begin
				phase_nxt = RS_HOLD;	// Illegal code, back to safe
			end
		endcase
	end

	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			phase <= RS_HOLD;	// All held
		end
		else
		begin
			phase <= phase_nxt;
		end
	end

	// Slot resets follow a low RST_OUT_ sample, one flop later
	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			rst_out_q  <= 1'b1;	// Looks like RST_OUT_ held
			slot_rst_q <= 1'b0;	// Slots held
		end
		else
		begin
			rst_out_q  <= rst_out_n;	// Sample per cycle
			slot_rst_q <= ~rst_out_q;	// Release on low sample
		end
	end

	// Levels for the pin stage
	always_comb
	begin
		status.pci_rst_n  = (phase != RS_HOLD);	// PCI out after first delay
		status.pmc_rst_n  = (phase == RS_ALL_UP);	// PMC last
		status.slot_rst_n = slot_rst_q;
	end

	// Counter parks, never runs past the PMC delay
	cnt_in_range: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		cnt <= PMC_DELAY
	);

	// Only a push can send the phase back
	phase_no_back_pci: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		(phase != RS_HOLD) |=> (phase != RS_HOLD)
	);

	phase_no_back_all: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		(phase == RS_ALL_UP) |=> (phase == RS_ALL_UP)
	);

endmodule

`default_nettype wire

// ==== verilog/irq_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_mapper
	import hip_pkg::*;
(
	input  logic     RST_CPLD_CLK,	// Board CPLD clock
	input  logic     PUSH_RST_,	// Push button, async
	input  logic     e1_int0,	// Ewok1 interrupt lines, async
	input  logic     e1_int1,
	input  logic     e2_int0,	// Ewok2 interrupt lines, async
	input  logic     e2_int1,
	output irq_vec_t irq_req	// Mapped requests
);

	irq_raw_t   sync1;	// First sync stage
	irq_raw_t   sync2;	// Second sync stage, safe to use
	logic [3:0] lines;	// Lines in A..D order, bit 0 = E1_INT0

	// Two-flop synchronizer on all four lines
	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			sync1 <= '0;	// No requests
			sync2 <= '0;
		end
		else
		begin
			sync1.e1_int0 <= e1_int0;
			sync1.e1_int1 <= e1_int1;
			sync1.e2_int0 <= e2_int0;
			sync1.e2_int1 <= e2_int1;
			sync2         <= sync1;	// Metastability settle
		end
	end

	// E1_INT0 -> A, E1_INT1 -> B, E2_INT0 -> C, E2_INT1 -> D
	assign lines = {sync2.e2_int1, sync2.e2_int0, sync2.e1_int1, sync2.e1_int0};

	always_comb
	begin
		irq_req.intx     = lines;	// Standard PCI INTx
		irq_req.pmc[3:0] = lines;	// Same order on PPMC
		irq_req.pmc[4]   = sync2.e1_int0 | sync2.e1_int1;	// Any Ewok1
		irq_req.pmc[5]   = sync2.e2_int0 | sync2.e2_int1;	// Any Ewok2
	end

	// Ewok1 summary needs a real Ewok1 request two edges back
	pmc4_has_source: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		irq_req.pmc[4] |-> $past(e1_int0 || e1_int1, 2)
	);

	// Same for Ewok2
	pmc5_has_source: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		irq_req.pmc[5] |-> $past(e2_int0 || e2_int1, 2)
	);

endmodule

`default_nettype wire

// ==== verilog/board_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_out_stage
	import hip_pkg::*;
(
	input  logic        RST_CPLD_CLK,	// Board CPLD clock
	input  logic        PUSH_RST_,	// Push button, async
	input  rst_status_t status,	// Reset levels from sequencer
	input  rst_state_e  phase,	// Sequencer phase, for masking
	input  irq_vec_t    irq_req,	// Mapped requests, active high
	input  logic        y1_rio_rst_n,	// Yeti1 RIO reset
	output logic        pci_rst_n,	// Yeti PCI reset pin
	output logic        pmc_rst_n,	// PPMC reset pin
	output logic        pci_slot_rst_n,	// PCI slot reset pin
	output logic        pcix_slot_rst_n,	// PCI-X slot reset pin
	output logic        e1_hd_rst_n,	// Ewok1 hard reset
	output logic        e2_hd_rst_n,	// Ewok2 hard reset
	output logic        y2_rio_rst_n,	// Yeti2 RIO reset
	output logic        inta_n,	// PCI INTx pins, active low
	output logic        intb_n,
	output logic        intc_n,
	output logic        intd_n,
	output logic [5:0]  pmc_int	// Extra PPMC interrupts, active high
);

	logic irq_open;	// Interrupts allowed out

	// Nothing leaves until the whole sequence is done
	assign irq_open = (phase == RS_ALL_UP);

	// Registered reset pins
	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			pci_rst_n       <= 1'b0;	// All held
			pmc_rst_n       <= 1'b0;
			pci_slot_rst_n  <= 1'b0;
			pcix_slot_rst_n <= 1'b0;
		end
		else
		begin
			pci_rst_n       <= status.pci_rst_n;
			pmc_rst_n       <= status.pmc_rst_n;
			pci_slot_rst_n  <= status.slot_rst_n;	// Both slot pins track
			pcix_slot_rst_n <= status.slot_rst_n;
		end
	end

	// Registered, masked interrupt pins
	always_ff @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
		begin
			{intd_n, intc_n, intb_n, inta_n} <= 4'hF;	// Inactive high
			pmc_int                          <= '0;	// Inactive low
		end
		else if (irq_open)
		begin
			{intd_n, intc_n, intb_n, inta_n} <= ~irq_req.intx;	// To active low
			pmc_int                          <= irq_req.pmc;
		end
		else
		begin
			{intd_n, intc_n, intb_n, inta_n} <= 4'hF;	// Masked during reset
			pmc_int                          <= '0;
		end
	end

	// Hard resets follow the Yeti1 RIO reset directly
	assign e1_hd_rst_n  = y1_rio_rst_n;
	assign e2_hd_rst_n  = y1_rio_rst_n;
	assign y2_rio_rst_n = y1_rio_rst_n;

	// No INTx while still fully in reset
	intx_quiet_in_hold: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		(phase == RS_HOLD) |-> (inta_n && intb_n && intc_n && intd_n)
	);

	// PMC comes out only behind PCI
	pmc_after_pci: assert property (
		@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		$rose(pmc_rst_n) |-> pci_rst_n
	);

endmodule

`default_nettype wire

// ==== verilog/hip_rst_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module hip_rst_int
	import hip_pkg::*;
#(
	parameter logic [CNT_W-1:0] PCI_DELAY = DEF_PCI_DELAY,	// PCI release delay
	parameter logic [CNT_W-1:0] PMC_DELAY = DEF_PMC_DELAY	// PMC release delay
)
(
	input  logic RST_CPLD_CLK,	// System clock up to 100 MHz
	input  logic PUSH_RST_,	// Push button hard reset
	input  logic RST_OUT_,	// Reset request from the PPMC
	input  logic Y1_RIO_RST_,	// Yeti1 RIO reset
	output logic PCI_RST_,	// Yeti PCI reset
	output logic PMC_RST_,	// PPMC reset
	output logic PCI_SLOT_RST_,	// PCI slots
	output logic PCIX_SLOT_RST_,	// PCI-X slots
	output logic E1_HD_RST_,	// Ewok1 hard reset
	output logic E2_HD_RST_,	// Ewok2 hard reset
	output logic Y2_RIO_RST_,	// Yeti2 RIO reset
	input  logic E1_INT0,	// Ewok1 interrupts
	input  logic E1_INT1,
	input  logic E2_INT0,	// Ewok2 interrupts
	input  logic E2_INT1,
	output logic INTA_,	// Standard PCI interrupts
	output logic INTB_,
	output logic INTC_,
	output logic INTD_,
	output logic PMC_INT0,	// Extra interrupts to the PPMC
	output logic PMC_INT1,
	output logic PMC_INT2,
	output logic PMC_INT3,
	output logic PMC_INT4,
	output logic PMC_INT5
);

	rst_status_t status;	// Sequencer reset levels
	rst_state_e  phase;	// Sequencer phase
	irq_vec_t    irq_req;	// Mapped interrupt requests

	rst_sequencer #(
		.PCI_DELAY (PCI_DELAY),
		.PMC_DELAY (PMC_DELAY)
	) rst_sequencer_inst (
		.RST_CPLD_CLK (RST_CPLD_CLK),
		.PUSH_RST_    (PUSH_RST_),
		.rst_out_n    (RST_OUT_),
		.status       (status),
		.phase        (phase)
	);

	irq_mapper irq_mapper_inst (
		.RST_CPLD_CLK (RST_CPLD_CLK),
		.PUSH_RST_    (PUSH_RST_),
		.e1_int0      (E1_INT0),
		.e1_int1      (E1_INT1),
		.e2_int0      (E2_INT0),
		.e2_int1      (E2_INT1),
		.irq_req      (irq_req)
	);

	board_out_stage board_out_stage_inst (
		.RST_CPLD_CLK    (RST_CPLD_CLK),
		.PUSH_RST_       (PUSH_RST_),
		.status          (status),
		.phase           (phase),
		.irq_req         (irq_req),
		.y1_rio_rst_n    (Y1_RIO_RST_),
		.pci_rst_n       (PCI_RST_),
		.pmc_rst_n       (PMC_RST_),
		.pci_slot_rst_n  (PCI_SLOT_RST_),
		.pcix_slot_rst_n (PCIX_SLOT_RST_),
		.e1_hd_rst_n     (E1_HD_RST_),
		.e2_hd_rst_n     (E2_HD_RST_),
		.y2_rio_rst_n    (Y2_RIO_RST_),
		.inta_n          (INTA_),
		.intb_n          (INTB_),
		.intc_n          (INTC_),
		.intd_n          (INTD_),
		.pmc_int         ({PMC_INT5, PMC_INT4, PMC_INT3, PMC_INT2, PMC_INT1, PMC_INT0})
	);

endmodule

`default_nettype wire

// ==== test/tb_hip_rst_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hip_rst_int
	import hip_pkg::*;
();

	localparam int PCI_DELAY  = 8;	// Short delays for simulation
	localparam int PMC_DELAY  = 20;
	localparam int CLK_PERIOD = 40;	// ns
	localparam int N_PUSH     = 4;	// Initial reset plus three pulses
	localparam int EDGE_CAP   = PMC_DELAY + 4;	// Edge counter parks here
	localparam int WATCHDOG_CYC = PMC_DELAY + 2 * N_PUSH * (PMC_DELAY + 4) + 200;

	logic       RST_CPLD_CLK;	// CPLD clock
	logic       PUSH_RST_;	// Push button
	logic       rst_out_n;	// RST_OUT_ from the PPMC
	logic       y1_rio_rst_n;	// Yeti1 RIO reset
	logic [3:0] ewok;	// Bit 0 = E1_INT0 ... bit 3 = E2_INT1
	logic       pci_rst_n;
	logic       pmc_rst_n;
	logic       pci_slot_rst_n;
	logic       pcix_slot_rst_n;
	logic       e1_hd_rst_n;
	logic       e2_hd_rst_n;
	logic       y2_rio_rst_n;
	logic       inta_n;
	logic       intb_n;
	logic       intc_n;
	logic       intd_n;
	logic [5:0] pmc_int;	// PMC_INT0..PMC_INT5
	logic [3:0] intx_n;	// D..A packed, active low

	integer     seed = 32'h5054_f47f;	// Fixed random seed
	int         err_cnt = 0;	// Assertion failures
	int         timeout_cnt = 0;	// Watchdog hits
	int         edges;	// Rising edges since push release
	logic [4:0] hist1 = '0;	// {RST_OUT_, ewok} one edge back
	logic [4:0] hist2 = '0;	// Two edges back
	logic [4:0] hist3 = '0;	// Three edges back
	irq_vec_t   exp_irq;	// Expected mapping of hist3

	hip_rst_int #(
		.PCI_DELAY (PCI_DELAY),
		.PMC_DELAY (PMC_DELAY)
	) hip_rst_int_inst (
		.RST_CPLD_CLK   (RST_CPLD_CLK),
		.PUSH_RST_      (PUSH_RST_),
		.RST_OUT_       (rst_out_n),
		.Y1_RIO_RST_    (y1_rio_rst_n),
		.PCI_RST_       (pci_rst_n),
		.PMC_RST_       (pmc_rst_n),
		.PCI_SLOT_RST_  (pci_slot_rst_n),
		.PCIX_SLOT_RST_ (pcix_slot_rst_n),
		.E1_HD_RST_     (e1_hd_rst_n),
		.E2_HD_RST_     (e2_hd_rst_n),
		.Y2_RIO_RST_    (y2_rio_rst_n),
		.E1_INT0        (ewok[0]),
		.E1_INT1        (ewok[1]),
		.E2_INT0        (ewok[2]),
		.E2_INT1        (ewok[3]),
		.INTA_          (inta_n),
		.INTB_          (intb_n),
		.INTC_          (intc_n),
		.INTD_          (intd_n),
		.PMC_INT0       (pmc_int[0]),
		.PMC_INT1       (pmc_int[1]),
		.PMC_INT2       (pmc_int[2]),
		.PMC_INT3       (pmc_int[3]),
		.PMC_INT4       (pmc_int[4]),
		.PMC_INT5       (pmc_int[5])
	);

	// Ewok lines to INTx A..D and PMC vector
	function automatic irq_vec_t map_ewok(input logic [3:0] lines);
		irq_vec_t v;
		v.intx = lines;	// E1_INT0 -> A ... E2_INT1 -> D
		v.pmc  = {lines[3] | lines[2], lines[1] | lines[0], lines};	// Ewok2 OR, Ewok1 OR, lines
		return v;
	endfunction

	always #(CLK_PERIOD / 2) RST_CPLD_CLK = ~RST_CPLD_CLK;

	assign intx_n  = {intd_n, intc_n, intb_n, inta_n};
	assign exp_irq = map_ewok(hist3[3:0]);

	// Edge count from push release, async clear like the DUT
	always @(posedge RST_CPLD_CLK or negedge PUSH_RST_)
	begin
		if (!PUSH_RST_)
			edges <= 0;
		else if (edges < EDGE_CAP)
			edges <= edges + 1;
	end

	// Input history for 3-edge latency checks
	always @(posedge RST_CPLD_CLK)
	begin
		hist1 <= {rst_out_n, ewok};
		hist2 <= hist1;
		hist3 <= hist2;
	end

	// n cycles of random interrupts, RST_OUT_ and RIO reset
	task automatic drive_random(input int n);
		repeat (n)
		begin
			@(posedge RST_CPLD_CLK);
			ewok <= $random(seed);
			if (($random(seed) & 3) == 0)
				rst_out_n <= ~rst_out_n;	// Toggle now and then
			y1_rio_rst_n <= (($random(seed) & 7) != 0);	// Mostly released
		end
	endtask

	// One-cycle push on the button
	task automatic pulse_push();
		@(posedge RST_CPLD_CLK);
		PUSH_RST_ <= 1'b0;
		@(posedge RST_CPLD_CLK);
		PUSH_RST_ <= 1'b1;
	endtask

	task automatic report_and_finish();
		$display("Checks done: %0d assertion errors, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	pci_release_time: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pci_rst_n == (edges >= PCI_DELAY + 2))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED pci_rst_n: got 0x%h, expected 0x%h, edge %0d", $sampled(pci_rst_n),
			$sampled(edges) >= PCI_DELAY + 2, $sampled(edges));
	end

	pmc_release_time: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pmc_rst_n == (edges >= PMC_DELAY + 2))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED pmc_rst_n: got 0x%h, expected 0x%h, edge %0d", $sampled(pmc_rst_n),
			$sampled(edges) >= PMC_DELAY + 2, $sampled(edges));
	end

	pmc_behind_pci: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pmc_rst_n |-> pci_rst_n)
	else begin
		err_cnt = err_cnt + 1;
		$display("PMC reset released while PCI reset still held");
	end

	slot_follows_rst_out: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		(edges >= 3) |-> (pci_slot_rst_n == ~hist3[4]))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED pci_slot_rst_n: got 0x%h, expected 0x%h", $sampled(pci_slot_rst_n),
			~$sampled(hist3[4]));
	end

	slot_pins_equal: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pcix_slot_rst_n == pci_slot_rst_n)
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED pcix_slot_rst_n: got 0x%h, expected 0x%h", $sampled(pcix_slot_rst_n),
			$sampled(pci_slot_rst_n));
	end

	hard_rst_fanout: assert property (@(posedge RST_CPLD_CLK)
		{e1_hd_rst_n, e2_hd_rst_n, y2_rio_rst_n} == {3{y1_rio_rst_n}})
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED {e1_hd_rst_n,e2_hd_rst_n,y2_rio_rst_n}: got 0x%h, expected 0x%h",
			$sampled({e1_hd_rst_n, e2_hd_rst_n, y2_rio_rst_n}), $sampled({3{y1_rio_rst_n}}));
	end

	intx_mapped: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pmc_rst_n |-> (intx_n == ~exp_irq.intx))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED intx_n: got 0x%h, expected 0x%h", $sampled(intx_n),
			~$sampled(exp_irq.intx));
	end

	pmc_int_mapped: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		pmc_rst_n |-> (pmc_int == exp_irq.pmc))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED pmc_int: got 0x%h, expected 0x%h", $sampled(pmc_int),
			$sampled(exp_irq.pmc));
	end

	irq_masked: assert property (@(posedge RST_CPLD_CLK) disable iff (!PUSH_RST_)
		!pmc_rst_n |-> (intx_n == 4'hF && pmc_int == 6'h00))
	else begin
		err_cnt = err_cnt + 1;
		$display("FAILED {intx_n,pmc_int}: got 0x%h, expected 0x%h",
			$sampled({intx_n, pmc_int}), 10'h3C0);
	end

	// Push drops every reset pin without waiting for a clock
	always @(negedge PUSH_RST_)
	begin
		#1;
		assert (!pci_rst_n && !pmc_rst_n && !pci_slot_rst_n && !pcix_slot_rst_n)
		else begin
			err_cnt = err_cnt + 1;
			$display("Push reset did not clear the reset pins at once");
		end
	end

	initial
	begin
		RST_CPLD_CLK = 1'b0;
		PUSH_RST_    = 1'b0;	// Held from the start
		rst_out_n    = 1'b1;
		y1_rio_rst_n = 1'b0;
		ewok         = 4'h0;
		repeat (3) @(posedge RST_CPLD_CLK);
		PUSH_RST_ <= 1'b1;
		drive_random(PMC_DELAY + 10);	// Full staged release
		pulse_push();
		drive_random(PCI_DELAY + 6);	// Restart, stop between PCI and PMC release
		pulse_push();
		drive_random(PCI_DELAY - 3);	// Stop before PCI release
		pulse_push();
		drive_random(PMC_DELAY + 40);	// Full release, long mapping run
		report_and_finish();
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		timeout_cnt = timeout_cnt + 1;
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/hip_pkg.sv
verilog/rst_sequencer.sv
verilog/irq_mapper.sv
verilog/board_out_stage.sv
verilog/hip_rst_int.sv
test/tb_hip_rst_int.sv
